// ==== design/bundleRouter.sv ====
//************************************************************
// picks bundle width, places and predicates the lanes,
// splits 128-bit scalar ops, result one cycle after strobe
//************************************************************

`timescale 1ns/10ps

module bundleRouter
(
	input logic clock,
	input logic reset,
	input logic bundleValid,
	input logic wexEnable,
	input logic dualEnable,
	decLaneIf.sink word0,
	decLaneIf.sink word1,
	decLaneIf.sink word2,
	output logic decValid,
	output wexDecPkg::bundleWidth_e bundleWords,
	output wexDecPkg::decLane_t laneA,
	output wexDecPkg::decLane_t laneB,
	output wexDecPkg::decLane_t laneC
);

	wexDecPkg::decLane_t lane0;
	wexDecPkg::decLane_t lane1;
	wexDecPkg::decLane_t lane2;
	wexDecPkg::decLane_t nextA;
	wexDecPkg::decLane_t nextB;
	wexDecPkg::decLane_t nextC;
	wexDecPkg::bundleWidth_e nextWidth;

	// fill in the predicate field of a class E word
	function automatic wexDecPkg::decLane_t applyPredicate
	(
		wexDecPkg::decLane_t fields,
		logic predicated,
		logic predFalse
	);
		wexDecPkg::decLane_t result;
		result = fields;
		if (predicated)
			result.uCmd[wexDecPkg::predHi:wexDecPkg::predLo] =
				predFalse ? wexDecPkg::condFalse : wexDecPkg::condTrue;
		return result;
	endfunction

	assign lane0 = applyPredicate({word0.regN, word0.regM, word0.regO, word0.imm,
		word0.uCmd, word0.uIxt}, word0.predicated, word0.predFalse);
	assign lane1 = applyPredicate({word1.regN, word1.regM, word1.regO, word1.imm,
		word1.uCmd, word1.uIxt}, word1.predicated, word1.predFalse);
	assign lane2 = applyPredicate({word2.regN, word2.regM, word2.regO, word2.imm,
		word2.uCmd, word2.uIxt}, word2.predicated, word2.predFalse);

	always_comb
	begin
		if (wexEnable && word0.wex && word1.wex)
			nextWidth = wexDecPkg::widthThree;
		else if (wexEnable && word0.wex)
			nextWidth = wexDecPkg::widthTwo;
		else
			nextWidth = wexDecPkg::widthOne;
	end

	// lanes go in reverse word order
	always_comb
	begin
		nextA = lane0;
		nextB = wexDecPkg::laneEmpty;
		nextC = wexDecPkg::laneEmpty;

		case (nextWidth)
			wexDecPkg::widthThree:
			begin
				nextA = lane2;
				nextB = lane1;
				nextC = lane0;
			end
			wexDecPkg::widthTwo:
			begin
				nextA = lane1;
				nextB = lane0;
			end
			default:
			begin
				if (dualEnable && lane0.uIxt == wexDecPkg::uIxtWide)
				begin
					nextB = lane0;	// high half on the odd/even partner regs
					nextB.regN[0] = !lane0.regN[0];
					nextB.regM[0] = !lane0.regM[0];
					nextB.regO[0] = !lane0.regO[0];
				end
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			decValid <= 1'b0;
		else
			decValid <= bundleValid;
	end

	always_ff @(posedge clock)
	begin
		if (bundleValid)
		begin
			bundleWords <= nextWidth;
			laneA <= nextA;
			laneB <= nextB;
			laneC <= nextC;
		end
	end

	// a chained bundle never leaves lane B undecoded
	assert property (@(posedge clock) disable iff (reset)
		(bundleValid && nextWidth != wexDecPkg::widthOne)
		|=> laneB.uCmd != wexDecPkg::uCmdInvalid);

	// a valid first word must come out on lane C of a 3-wide bundle
	assert property (@(posedge clock) disable iff (reset)
		(bundleValid && nextWidth == wexDecPkg::widthThree
			&& word0.uCmd != wexDecPkg::uCmdInvalid)
		|=> laneC.uCmd != wexDecPkg::uCmdInvalid);

endmodule

// ==== design/decLaneIf.sv ====
//************************************************************
// one decoded word, lane decoder to bundle router
//************************************************************

`timescale 1ns/10ps

interface decLaneIf;

	logic [5:0] regN;
	logic [5:0] regM;
	logic [5:0] regO;
	logic [wexDecPkg::immWidth-1:0] imm;
	logic [7:0] uCmd;	// predicate field still condAlways here
	logic [7:0] uIxt;
	logic wex;
	logic predicated;	// class E word
	logic predFalse;	// run on predicate false

	modport source
	(
		output regN, regM, regO, imm, uCmd, uIxt,
		output wex, predicated, predFalse
	);

	modport sink
	(
		input regN, regM, regO, imm, uCmd, uIxt,
		input wex, predicated, predFalse
	);

endinterface

// ==== design/decodeCfgRegs.sv ====
//************************************************************
// decode switch register, WEX enable and dual-lane enable
//************************************************************

`timescale 1ns/10ps

module decodeCfgRegs
(
	input logic clock,
	input logic reset,
	input logic cfgWrite,
	input logic [1:0] cfgData,
	output logic wexEnable,
	output logic dualEnable,
	output logic [1:0] cfgState
);

	always_ff @(posedge clock)
	begin
		if (reset)
			cfgState <= wexDecPkg::cfgReset;	// both switches on
		else if (cfgWrite)
			cfgState <= cfgData;
	end

	assign wexEnable = cfgState[wexDecPkg::cfgWexBit];
	assign dualEnable = cfgState[wexDecPkg::cfgDualBit];

	// a write must not load unknown switches
	assert property (@(posedge clock) disable iff (reset)
		cfgWrite |-> !$isunknown(cfgData));

endmodule

// ==== design/laneOpDecoder.sv ====
//************************************************************
// decodes one 32-bit word into lane fields and flags
// purely combinational, one instance per bundle word
//************************************************************

`timescale 1ns/10ps

module laneOpDecoder
(
	input logic [31:0] word,
	decLaneIf.source lane
);

	logic [3:0] wordClass;
	logic [5:0] opField;
	logic [wexDecPkg::immWidth-1:0] immExt;
	logic opKnown;
	logic valid;

	assign wordClass = word[wexIsaPkg::classHi:wexIsaPkg::classLo];
	assign opField = word[wexIsaPkg::opHi:wexIsaPkg::opLo];

	// sign extend the 14-bit immediate
	assign immExt =
	{
		{(wexDecPkg::immWidth - (wexIsaPkg::immHi - wexIsaPkg::immLo + 1))
			{word[wexIsaPkg::immHi]}},
		word[wexIsaPkg::immHi:wexIsaPkg::immLo]
	};

	always_comb
	begin
		opKnown = 1'b1;
		lane.regN = wexIsaPkg::regZzr;
		lane.regM = wexIsaPkg::regZzr;
		lane.regO = wexIsaPkg::regZzr;
		lane.imm = '0;
		lane.uIxt = 8'h00;

		case (opField)
			wexIsaPkg::opNop:
				opKnown = 1'b1;	// no operands
			wexIsaPkg::opAlu3, wexIsaPkg::opAluX:
			begin
				lane.regN = word[wexIsaPkg::regNHi:wexIsaPkg::regNLo];
				lane.regM = word[wexIsaPkg::regMHi:wexIsaPkg::regMLo];
				lane.regO = word[wexIsaPkg::regOHi:wexIsaPkg::regOLo];
				lane.uIxt = (opField == wexIsaPkg::opAluX) ? wexDecPkg::uIxtWide : 8'h00;
			end
			wexIsaPkg::opLdi:
			begin
				lane.regN = word[wexIsaPkg::regNHi:wexIsaPkg::regNLo];
				lane.imm = immExt;
			end
			wexIsaPkg::opMov:
				lane.regN = word[wexIsaPkg::regNHi:wexIsaPkg::regNLo];
			default:
				opKnown = 1'b0;
		endcase

		// mov reads regM, kept apart from the shared case above
		if (opField == wexIsaPkg::opMov)
			lane.regM = word[wexIsaPkg::regMHi:wexIsaPkg::regMLo];

		valid = opKnown &&
			(wordClass == wexIsaPkg::wordClassE || wordClass == wexIsaPkg::wordClassF);

		if (!valid)
		begin
			lane.regN = wexIsaPkg::regZzr;
			lane.regM = wexIsaPkg::regZzr;
			lane.regO = wexIsaPkg::regZzr;
			lane.imm = '0;
			lane.uIxt = 8'h00;
		end

		lane.uCmd = valid ? {wexDecPkg::condAlways, opField} : wexDecPkg::uCmdInvalid;

		// an invalid word never chains and is never predicated
		lane.wex = valid && word[wexIsaPkg::wexBit];
		lane.predicated = valid && (wordClass == wexIsaPkg::wordClassE);
		lane.predFalse = valid && word[wexIsaPkg::predFalseBit];
	end

endmodule

// ==== design/wexDecPkg.sv ====
//************************************************************
// decoded lane layout, predicate conditions, bundle widths
//************************************************************

package wexDecPkg;

	localparam int immWidth = 33;

	// uCmd is {predCond_e, opCode_e}
	localparam int predHi = 7;
	localparam int predLo = 6;

	localparam logic [7:0] uCmdInvalid = 8'h3F;
	localparam logic [7:0] uIxtWide = 8'hC0;	// marks a dual-lane op

	typedef enum logic [1:0]
	{
		condAlways = 2'b00,
		condTrue = 2'b10,
		condFalse = 2'b11
	} predCond_e;

	typedef enum logic [1:0]
	{
		widthOne = 2'd1,
		widthTwo = 2'd2,
		widthThree = 2'd3
	} bundleWidth_e;

	// one output lane as the router places it
	typedef struct packed
	{
		logic [5:0] regN;
		logic [5:0] regM;
		logic [5:0] regO;
		logic [immWidth-1:0] imm;
		logic [7:0] uCmd;
		logic [7:0] uIxt;
	} decLane_t;

	localparam decLane_t laneEmpty = '{
		regN: wexIsaPkg::regZzr,
		regM: wexIsaPkg::regZzr,
		regO: wexIsaPkg::regZzr,
		imm: '0,
		uCmd: 8'h00,
		uIxt: 8'h00
	};

	// switch register layout
	localparam logic [1:0] cfgReset = 2'b11;
	localparam int cfgWexBit = 0;
	localparam int cfgDualBit = 1;

endpackage

// ==== design/wexDecodeTop.sv ====
//************************************************************
// issue decode slice, three lane decoders feeding the router
// bundle strobed in, lanes A/B/C valid one cycle later
//************************************************************

`timescale 1ns/10ps

module wexDecodeTop
(
	input logic clock,
	input logic reset,
	input logic [95:0] bundle,
	input logic bundleValid,
	input logic cfgWrite,
	input logic [1:0] cfgData,
	output logic [1:0] cfgState,
	output logic decValid,
	output wexDecPkg::bundleWidth_e bundleWords,
	output logic [5:0] laneARegN,
	output logic [5:0] laneARegM,
	output logic [5:0] laneARegO,
	output logic [wexDecPkg::immWidth-1:0] laneAImm,
	output logic [7:0] laneAUCmd,
	output logic [7:0] laneAUIxt,
	output logic [5:0] laneBRegN,
	output logic [5:0] laneBRegM,
	output logic [5:0] laneBRegO,
	output logic [wexDecPkg::immWidth-1:0] laneBImm,
	output logic [7:0] laneBUCmd,
	output logic [7:0] laneBUIxt,
	output logic [5:0] laneCRegN,
	output logic [5:0] laneCRegM,
	output logic [5:0] laneCRegO,
	output logic [wexDecPkg::immWidth-1:0] laneCImm,
	output logic [7:0] laneCUCmd,
	output logic [7:0] laneCUIxt
);

	logic wexEnable;
	logic dualEnable;

	decLaneIf word0If ();
	decLaneIf word1If ();
	decLaneIf word2If ();

	laneOpDecoder laneOpDecoder0 (.word(bundle[31:0]), .lane(word0If));
	laneOpDecoder laneOpDecoder1 (.word(bundle[63:32]), .lane(word1If));
	laneOpDecoder laneOpDecoder2 (.word(bundle[95:64]), .lane(word2If));

	bundleRouter bundleRouter_i
	(
		.clock(clock),
		.reset(reset),
		.bundleValid(bundleValid),
		.wexEnable(wexEnable),
		.dualEnable(dualEnable),
		.word0(word0If),
		.word1(word1If),
		.word2(word2If),
		.decValid(decValid),
		.bundleWords(bundleWords),
		.laneA({laneARegN, laneARegM, laneARegO, laneAImm, laneAUCmd, laneAUIxt}),
		.laneB({laneBRegN, laneBRegM, laneBRegO, laneBImm, laneBUCmd, laneBUIxt}),
		.laneC({laneCRegN, laneCRegM, laneCRegO, laneCImm, laneCUCmd, laneCUIxt})
	);

	decodeCfgRegs decodeCfgRegs_i
	(
		.clock(clock),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgData(cfgData),
		.wexEnable(wexEnable),
		.dualEnable(dualEnable),
		.cfgState(cfgState)
	);

endmodule

// ==== design/wexIsaPkg.sv ====
//************************************************************
// instruction encoding of the 32-bit issue word
// word classes, opcodes, field positions, null register
//************************************************************

package wexIsaPkg;

	// word classes in bits 31..28
	localparam logic [3:0] wordClassE = 4'hE;	// predicated
	localparam logic [3:0] wordClassF = 4'hF;	// unconditional

	// field positions
	localparam int classHi = 31;
	localparam int classLo = 28;
	localparam int wexBit = 27;	// next word issues alongside
	localparam int predFalseBit = 26;
	localparam int opHi = 25;
	localparam int opLo = 20;
	localparam int regNHi = 19;
	localparam int regNLo = 14;
	localparam int regMHi = 13;
	localparam int regMLo = 8;
	localparam int regOHi = 7;
	localparam int regOLo = 2;

	// immediate overlaps regM/regO, sign extended by the decoder
	localparam int immHi = 13;
	localparam int immLo = 0;

	localparam logic [5:0] regZzr = 6'h3F;	// null register

	typedef enum logic [5:0]
	{
		opNop = 6'h00,
		opAlu3 = 6'h01,	// regN = regM op regO
		opLdi = 6'h02,	// regN = imm
		opAluX = 6'h03,	// 128-bit form of opAlu3
		opMov = 6'h04
	} opCode_e;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the decode slice testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module wexDecodeTb -o wexDecodeSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/wexDecodeSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulator exited with status $simStatus"
	exit 1
fi
exit 0

// ==== tb.f ====
design/wexIsaPkg.sv
design/wexDecPkg.sv
design/decLaneIf.sv
design/laneOpDecoder.sv
design/bundleRouter.sv
design/decodeCfgRegs.sv
design/wexDecodeTop.sv
test/wexDecodeTb.sv

// ==== test/wexDecodeTb.sv ====
//************************************************************
// testbench for the issue decode slice, directed + random
// bundles checked against a reference decode of each strobe
//************************************************************

`timescale 1ns/10ps

module wexDecodeTb;

	localparam int resetCycles = 8;
	localparam int randomCount = 400;
	localparam int directedBudget = 40;	// directed bundles and idles

	typedef struct packed
	{
		wexDecPkg::decLane_t lane;
		logic wex;
	} wordDec_t;

	typedef struct packed
	{
		logic [1:0] width;
		wexDecPkg::decLane_t a;
		wexDecPkg::decLane_t b;
		wexDecPkg::decLane_t c;
	} expect_t;

	logic clock;
	logic reset;
	logic [95:0] bundle;
	logic bundleValid;
	logic cfgWrite;
	logic [1:0] cfgData;
	logic [1:0] cfgState;
	logic decValid;
	wexDecPkg::bundleWidth_e bundleWords;
	logic [5:0] laneARegN, laneARegM, laneARegO;
	logic [5:0] laneBRegN, laneBRegM, laneBRegO;
	logic [5:0] laneCRegN, laneCRegM, laneCRegO;
	logic [32:0] laneAImm, laneBImm, laneCImm;
	logic [7:0] laneAUCmd, laneAUIxt, laneBUCmd, laneBUIxt, laneCUCmd, laneCUIxt;

	integer seed = 98;
	logic [1:0] modelCfg;	// switches as the next strobe will see them
	expect_t expQ[$];
	string nameQ[$];
	expect_t current;
	string currentName;

	wexDecodeTop wexDecodeTop_i (.*);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = !clock;
	end

	initial
	begin
		repeat (resetCycles + 2 * (directedBudget + randomCount) + 100) @(posedge clock);
		$display("watchdog expired, the DUT stopped producing results");
		$display("ERRORS FOUND");
		$fatal(1);
	end

	function automatic wexDecPkg::decLane_t emptyLane();
		wexDecPkg::decLane_t e;
		e.regN = 6'h3F;
		e.regM = 6'h3F;
		e.regO = 6'h3F;
		e.imm = '0;
		e.uCmd = 8'h00;
		e.uIxt = 8'h00;
		return e;
	endfunction

	// one word per the encoding rules
	function automatic wordDec_t decodeWord(logic [31:0] w);
		wordDec_t d;
		logic [3:0] cls;
		logic [5:0] op;
		logic known;
		cls = w[31:28];
		op = w[25:20];
		known = (op == wexIsaPkg::opNop) || (op == wexIsaPkg::opAlu3)
			|| (op == wexIsaPkg::opLdi) || (op == wexIsaPkg::opAluX)
			|| (op == wexIsaPkg::opMov);
		d.lane = emptyLane();
		d.lane.uCmd = 8'h3F;	// invalid unless proven otherwise
		d.wex = 1'b0;
		if (known && (cls == 4'hE || cls == 4'hF))
		begin
			d.wex = w[27];
			d.lane.uCmd = {2'b00, op};
			if (cls == 4'hE)
				d.lane.uCmd[7:6] = w[26] ? 2'b11 : 2'b10;
			if (op != wexIsaPkg::opNop)
				d.lane.regN = w[19:14];
			if (op == wexIsaPkg::opAlu3 || op == wexIsaPkg::opAluX || op == wexIsaPkg::opMov)
				d.lane.regM = w[13:8];
			if (op == wexIsaPkg::opAlu3 || op == wexIsaPkg::opAluX)
				d.lane.regO = w[7:2];
			if (op == wexIsaPkg::opLdi)
				d.lane.imm = {{19{w[13]}}, w[13:0]};
			if (op == wexIsaPkg::opAluX)
				d.lane.uIxt = 8'hC0;
		end
		return d;
	endfunction

	function automatic expect_t refDecode(logic [95:0] b, logic wexOn, logic dualOn);
		wordDec_t w0, w1, w2;
		expect_t e;
		w0 = decodeWord(b[31:0]);
		w1 = decodeWord(b[63:32]);
		w2 = decodeWord(b[95:64]);
		e.b = emptyLane();
		e.c = emptyLane();
		if (wexOn && w0.wex && w1.wex)
		begin
			e.width = 2'd3;
			e.a = w2.lane;
			e.b = w1.lane;
			e.c = w0.lane;
		end
		else if (wexOn && w0.wex)
		begin
			e.width = 2'd2;
			e.a = w1.lane;
			e.b = w0.lane;
		end
		else
		begin
			e.width = 2'd1;
			e.a = w0.lane;
			if (dualOn && w0.lane.uIxt == 8'hC0)
			begin
				e.b = w0.lane;	// partner registers
				e.b.regN = w0.lane.regN ^ 6'h01;
				e.b.regM = w0.lane.regM ^ 6'h01;
				e.b.regO = w0.lane.regO ^ 6'h01;
			end
		end
		return e;
	endfunction

	function automatic logic [31:0] makeWord(logic [3:0] cls, logic wexB, logic pf,
		logic [5:0] op, logic [5:0] n, logic [5:0] m, logic [5:0] o);
		return {cls, wexB, pf, op, n, m, o, 2'b00};
	endfunction

	task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic checkLane(string tag, wexDecPkg::decLane_t e, logic [5:0] n,
		logic [5:0] m, logic [5:0] o, logic [32:0] imm, logic [7:0] cmd, logic [7:0] ixt);
		checkValue({tag, " regN"}, 64'(e.regN), 64'(n));
		checkValue({tag, " regM"}, 64'(e.regM), 64'(m));
		checkValue({tag, " regO"}, 64'(e.regO), 64'(o));
		checkValue({tag, " imm"}, 64'(e.imm), 64'(imm));
		checkValue({tag, " uCmd"}, 64'(e.uCmd), 64'(cmd));
		checkValue({tag, " uIxt"}, 64'(e.uIxt), 64'(ixt));
	endtask

	task automatic driveBundle(string name, logic [95:0] b, logic write, logic [1:0] data);
		@(posedge clock);
		bundle <= b;
		bundleValid <= 1'b1;
		cfgWrite <= write;
		cfgData <= data;
		expQ.push_back(refDecode(b, modelCfg[0], modelCfg[1]));
		nameQ.push_back(name);
		if (write)
			modelCfg = data;	// lands after this bundle is sampled
	endtask

	task automatic idleCycle();
		@(posedge clock);
		bundleValid <= 1'b0;
		cfgWrite <= 1'b0;
	endtask

	task automatic randomWord(output logic [31:0] w);
		logic [31:0] r;
		logic [31:0] r2;
		logic [3:0] cls;
		logic [5:0] op;
		r = $random(seed);
		r2 = $random(seed);
		if (r[1:0] == 2'b00)
			cls = r[5:2];	// mostly illegal classes
		else if (r[1])
			cls = 4'hE;
		else
			cls = 4'hF;
		if (r[8:6] <= 3'd4)
			op = {3'b000, r[8:6]};
		else
			op = r[14:9];
		w = {cls, r[16], r[17], op, r2[19:0]};
	endtask

	always @(negedge clock)
	begin
		if (!reset && decValid)
		begin
			if (expQ.size() == 0)
			begin
				$display("decValid went high with no bundle outstanding");
				$display("ERRORS FOUND");
				$fatal(1);
			end
			else
			begin
				current = expQ.pop_front();
				currentName = nameQ.pop_front();
				checkValue({currentName, " width"}, 64'(current.width), 64'(bundleWords));
				checkLane({currentName, " lane A"}, current.a, laneARegN, laneARegM,
					laneARegO, laneAImm, laneAUCmd, laneAUIxt);
				checkLane({currentName, " lane B"}, current.b, laneBRegN, laneBRegM,
					laneBRegO, laneBImm, laneBUCmd, laneBUIxt);
				checkLane({currentName, " lane C"}, current.c, laneCRegN, laneCRegM,
					laneCRegO, laneCImm, laneCUCmd, laneCUIxt);
			end
		end
	end

	initial
	begin
		logic [31:0] w0, w1, w2, r;
		logic [95:0] threeWide;
		logic [95:0] aluXScalar;
		reset = 1'b1;
		bundle = '0;
		bundleValid = 1'b1;	// strobe and switch write held through reset
		cfgWrite = 1'b1;
		cfgData = 2'b00;
		modelCfg = 2'b11;
		threeWide = {makeWord(4'hF, 1'b0, 1'b0, wexIsaPkg::opMov, 6'd7, 6'd8, 6'd9),
			{4'hF, 1'b1, 1'b0, wexIsaPkg::opLdi, 6'd4, 14'h1F00},
			makeWord(4'hF, 1'b1, 1'b0, wexIsaPkg::opAlu3, 6'd1, 6'd2, 6'd3)};
		aluXScalar = {64'h0, makeWord(4'hF, 1'b0, 1'b0, wexIsaPkg::opAluX, 6'd20, 6'd33, 6'd62)};
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;
		bundleValid <= 1'b0;
		cfgWrite <= 1'b0;
		@(negedge clock);
		checkValue("reset decValid", 64'd0, 64'(decValid));
		checkValue("reset cfgState", 64'd3, 64'(cfgState));

		// scalar forms, filler words above word0
		driveBundle("scalar nop", {64'h0, makeWord(4'hF, 1'b0, 1'b0,
			wexIsaPkg::opNop, 6'd1, 6'd2, 6'd3)}, 1'b0, 2'b00);
		driveBundle("scalar alu3", {64'h0, makeWord(4'hF, 1'b0, 1'b0,
			wexIsaPkg::opAlu3, 6'd5, 6'd6, 6'd7)}, 1'b0, 2'b00);
		driveBundle("scalar ldi neg", {64'h0, 4'hF, 1'b0, 1'b0, wexIsaPkg::opLdi,
			6'd9, 14'h2ABC}, 1'b0, 2'b00);
		driveBundle("scalar ldi pos", {64'h0, 4'hF, 1'b0, 1'b0, wexIsaPkg::opLdi,
			6'd10, 14'h0123}, 1'b0, 2'b00);
		driveBundle("scalar mov", {64'h0, makeWord(4'hF, 1'b0, 1'b0,
			wexIsaPkg::opMov, 6'd10, 6'd11, 6'd12)}, 1'b0, 2'b00);
		driveBundle("bad class", {threeWide[95:32], makeWord(4'h3, 1'b1, 1'b0,
			wexIsaPkg::opAlu3, 6'd1, 6'd2, 6'd3)}, 1'b0, 2'b00);
		driveBundle("bad opcode", {64'h0, makeWord(4'hF, 1'b0, 1'b0,
			6'h2A, 6'd1, 6'd2, 6'd3)}, 1'b0, 2'b00);
		driveBundle("scalar aluX", aluXScalar, 1'b0, 2'b00);
		idleCycle();

		// widths back to back
		driveBundle("two wide", {threeWide[95:64], threeWide[95:64],
			makeWord(4'hF, 1'b1, 1'b0, wexIsaPkg::opMov, 6'd4, 6'd5, 6'd6)}, 1'b0, 2'b00);
		driveBundle("three wide", threeWide, 1'b0, 2'b00);
		driveBundle("three wide w2 wex", threeWide | 96'h0800_0000 << 64, 1'b0, 2'b00);
		driveBundle("pred three", {makeWord(4'hF, 1'b0, 1'b0, wexIsaPkg::opNop, 6'd0, 6'd0,
			6'd0), makeWord(4'hE, 1'b1, 1'b1, wexIsaPkg::opMov, 6'd2, 6'd3, 6'd4),
			makeWord(4'hE, 1'b1, 1'b0, wexIsaPkg::opAlu3, 6'd5, 6'd6, 6'd7)}, 1'b0, 2'b00);
		driveBundle("pred scalar", {64'h0, 4'hE, 1'b0, 1'b1, wexIsaPkg::opLdi,
			6'd11, 14'h3FFF}, 1'b0, 2'b00);
		idleCycle();

		// switch writes apply from the next strobe on
		driveBundle("wex off write", threeWide, 1'b1, 2'b10);
		driveBundle("wex off", threeWide, 1'b0, 2'b00);
		idleCycle();
		@(negedge clock);
		checkValue("cfgState wex off", 64'd2, 64'(cfgState));
		driveBundle("dual off write", aluXScalar, 1'b1, 2'b00);
		driveBundle("dual off", aluXScalar, 1'b0, 2'b00);
		driveBundle("both on write", aluXScalar, 1'b1, 2'b11);
		driveBundle("dual on", aluXScalar, 1'b0, 2'b00);
		idleCycle();

		for (int i = 0; i < randomCount; i++)
		begin
			randomWord(w0);
			randomWord(w1);
			randomWord(w2);
			r = $random(seed);
			driveBundle("random", {w2, w1, w0}, r[3:0] == 4'h0, r[5:4]);
			if (r[7:6] == 2'b00)
				idleCycle();
		end
		idleCycle();
		repeat (3) @(posedge clock);	// one-cycle latency drains the queue
		@(negedge clock);
		if (expQ.size() != 0)
		begin
			$display("%0d bundles never produced a result", expQ.size());
			$display("ERRORS FOUND");
			$fatal(1);
		end
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule
